//--- sdmac_settings.svh
// SDMAC constants for bus widths, identification words and status/control bit positions
`ifndef SDMAC_SETTINGS_SVH
`define SDMAC_SETTINGS_SVH

// CPU bus widths
`define SDMAC_ADDR_W 8
`define SDMAC_DATA_W 32

// Identification words seen by the driver
`define SDMAC_VERSION 32'h0000_0105  // Read at 0x20
`define SDMAC_DEV_ID  32'h0000_0003  // Read at 0x2C

// ISTR layout
`define ISTR_DMA_ACT_BIT 0  // DMA running
`define ISTR_FE_BIT      1  // Flush done
`define ISTR_INT_P_BIT   4  // Interrupt pending

// CONTR layout with only the interrupt enable interpreted here
`define CONTR_INTEN_BIT 2

`endif

//--- sdmac_pkg.sv
// SDMAC shared types for register selection, decoder cycle state and register snapshot
`include "sdmac_settings.svh"

package sdmac_pkg;

  // Decoded target of one CPU access
  typedef enum logic [3:0] {
    SEL_NONE,        // Unlisted offset
    SEL_WTC,         // 0x04
    SEL_CONTR,       // 0x08
    SEL_ACR,         // 0x0C
    SEL_ST_DMA,      // 0x10
    SEL_FLUSH,       // 0x14
    SEL_CLR_INT,     // 0x18
    SEL_ISTR,        // 0x1C
    SEL_VERSION,     // 0x20
    SEL_FLASH_ADDR,  // 0x24
    SEL_FLASH_DATA,  // 0x28
    SEL_DEV,         // 0x2C
    SEL_SP_DMA,      // 0x3C
    SEL_WD,          // 0x40 to 0x4F
    SEL_SSPBDAT,     // 0x58
    SEL_DSP          // 0x5C
  } reg_sel_e;

  // Bus cycle sequencing in the decoder
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DECODE,        // valid high for this one cycle
    ST_ACK,           // dtack_n just asserted
    ST_WAIT_RELEASE   // CPU still holding as_n low
  } dec_state_e;

  // Current value of every readable register
  typedef struct packed {
    logic [`SDMAC_DATA_W-1:0] contr;
    logic [`SDMAC_DATA_W-1:0] acr;
    logic [`SDMAC_DATA_W-1:0] wtc;
    logic [`SDMAC_DATA_W-1:0] istr;
    logic [`SDMAC_DATA_W-1:0] flash_addr;
    logic [`SDMAC_DATA_W-1:0] flash_data;
    logic [`SDMAC_DATA_W-1:0] sspbdat;
  } sdmac_regs_t;

endpackage

//--- reg_strobe_if.sv
// Register strobe interface carrying one decoded CPU access to the execute and result stages
`timescale 1ns/1ns
`include "sdmac_settings.svh"

interface reg_strobe_if import sdmac_pkg::*; ();

  logic                     valid;  // One cycle per accepted bus cycle
  reg_sel_e                 sel;
  logic                     write;  // High for a CPU write
  logic [`SDMAC_DATA_W-1:0] wdata;

  modport decoder_mp (
    output valid,
    output sel,
    output write,
    output wdata
  );

  modport exec_mp (
    input valid,
    input sel,
    input write,
    input wdata
  );

  // Read data path has no use for wdata
  modport result_mp (
    input valid,
    input sel,
    input write
  );

endinterface

//--- addr_decoder.sv
// Address decoder that samples the CPU request, decodes the offset and sequences the bus cycle
`timescale 1ns/1ns
`include "sdmac_settings.svh"

module addr_decoder import sdmac_pkg::*; (
  input  logic                     sclk,
  input  logic                     rst_n,
  input  logic [`SDMAC_ADDR_W-1:0] addr,
  input  logic                     dmac_n,
  input  logic                     as_n,
  input  logic                     rw,
  input  logic [`SDMAC_DATA_W-1:0] wdata,
  reg_strobe_if.decoder_mp         strobe,
  output logic                     wd_req
);

  dec_state_e               state;
  reg_sel_e                 sel_dec;
  reg_sel_e                 sel_q;
  logic                     write_q;
  logic [`SDMAC_DATA_W-1:0] wdata_q;
  logic                     req;
  logic                     accept;

  // Chip select qualifies the address strobe
  assign req    = ~(dmac_n | as_n);
  assign accept = (state == ST_IDLE) && req;

  always_comb begin
    case (addr)
      8'h04:   sel_dec = SEL_WTC;
      8'h08:   sel_dec = SEL_CONTR;
      8'h0C:   sel_dec = SEL_ACR;
      8'h10:   sel_dec = SEL_ST_DMA;
      8'h14:   sel_dec = SEL_FLUSH;
      8'h18:   sel_dec = SEL_CLR_INT;
      8'h1C:   sel_dec = SEL_ISTR;
      8'h20:   sel_dec = SEL_VERSION;
      8'h24:   sel_dec = SEL_FLASH_ADDR;
      8'h28:   sel_dec = SEL_FLASH_DATA;
      8'h2C:   sel_dec = SEL_DEV;
      8'h3C:   sel_dec = SEL_SP_DMA;
      8'h58:   sel_dec = SEL_SSPBDAT;
      8'h5C:   sel_dec = SEL_DSP;
      // Whole 0x4X page belongs to the SCSI chip
      default: sel_dec = (addr[7:4] == 4'h4) ? SEL_WD : SEL_NONE;
    endcase
  end

  // Cycle sequencing with a new access only after as_n has been seen high
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      sel_q   <= SEL_NONE;
      write_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            state   <= ST_DECODE;
            sel_q   <= sel_dec;
            write_q <= ~rw;  // rw high means read
          end
        end
        ST_DECODE: state <= ST_ACK;
        ST_ACK: state <= as_n ? ST_IDLE : ST_WAIT_RELEASE;
        ST_WAIT_RELEASE: begin
          if (as_n) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge sclk) begin
    if (accept) begin
      wdata_q <= wdata;
    end
  end

  assign strobe.valid = (state == ST_DECODE);
  assign strobe.sel   = sel_q;
  assign strobe.write = write_q;
  assign strobe.wdata = wdata_q;

  // SCSI chip request lasts from the acknowledge to the release
  assign wd_req = ((state == ST_ACK) || (state == ST_WAIT_RELEASE)) && (sel_q == SEL_WD);

  a_valid_single: assert property (@(posedge sclk) disable iff (!rst_n)
    strobe.valid |=> !strobe.valid)
    else $error("strobe valid held for more than one cycle");

endmodule

//--- dmac_regs.sv
// DMA controller register block applying CPU writes, action strobes and status tracking
`timescale 1ns/1ns
`include "sdmac_settings.svh"

module dmac_regs import sdmac_pkg::*; (
  input  logic          sclk,
  input  logic          rst_n,
  reg_strobe_if.exec_mp strobe,
  input  logic          scsi_irq,
  input  logic          dma_word,
  output sdmac_regs_t   regs,
  output logic          int_n,
  output logic          dma_active
);

  logic [`SDMAC_DATA_W-1:0] contr;
  logic [`SDMAC_DATA_W-1:0] acr;
  logic [`SDMAC_DATA_W-1:0] wtc;
  logic [`SDMAC_DATA_W-1:0] istr;
  logic [`SDMAC_DATA_W-1:0] flash_addr;
  logic [`SDMAC_DATA_W-1:0] flash_data;
  logic [`SDMAC_DATA_W-1:0] sspbdat;
  logic                     fe;        // Flush done
  logic                     int_p;     // Interrupt pending
  logic                     irq_q;
  logic                     irq_rise;
  logic                     wr_en;
  logic                     st_dma;
  logic                     sp_dma;
  logic                     flush;
  logic                     clr_int;

  assign wr_en = strobe.valid & strobe.write;

  // Actions fire on reads and writes alike
  assign st_dma  = strobe.valid && (strobe.sel == SEL_ST_DMA);
  assign sp_dma  = strobe.valid && (strobe.sel == SEL_SP_DMA);
  assign flush   = strobe.valid && (strobe.sel == SEL_FLUSH);
  assign clr_int = strobe.valid && (strobe.sel == SEL_CLR_INT);

  assign irq_rise = scsi_irq & ~irq_q;

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      contr      <= '0;
      acr        <= '0;
      flash_addr <= '0;
      flash_data <= '0;
      sspbdat    <= '0;
    end else if (wr_en) begin
      case (strobe.sel)
        SEL_CONTR:      contr      <= strobe.wdata;
        SEL_ACR:        acr        <= strobe.wdata;
        SEL_FLASH_ADDR: flash_addr <= strobe.wdata;
        SEL_FLASH_DATA: flash_data <= strobe.wdata;
        SEL_SSPBDAT:    sspbdat    <= strobe.wdata;
        default: ;  // Read-only and unlisted targets ignore writes
      endcase
    end
  end

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      dma_active <= 1'b0;
    end else if (st_dma) begin
      dma_active <= 1'b1;
    end else if (sp_dma) begin
      dma_active <= 1'b0;
    end
  end

  // Transfer counter restarted by each ST_DMA
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      wtc <= '0;
    end else if (st_dma) begin
      wtc <= '0;
    end else if (dma_active && dma_word) begin
      wtc <= wtc + 1'b1;
    end
  end

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      fe <= 1'b0;
    end else if (st_dma) begin
      fe <= 1'b0;
    end else if (flush && dma_active) begin
      fe <= 1'b1;
    end
  end

  // A new edge wins over a simultaneous clear so no interrupt is lost
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      irq_q <= 1'b0;
      int_p <= 1'b0;
    end else begin
      irq_q <= scsi_irq;
      if (irq_rise) begin
        int_p <= 1'b1;
      end else if (clr_int) begin
        int_p <= 1'b0;
      end
    end
  end

  always_comb begin
    istr                    = '0;
    istr[`ISTR_DMA_ACT_BIT] = dma_active;
    istr[`ISTR_FE_BIT]      = fe;
    istr[`ISTR_INT_P_BIT]   = int_p;
  end

  always_comb begin
    regs.contr      = contr;
    regs.acr        = acr;
    regs.wtc        = wtc;
    regs.istr       = istr;
    regs.flash_addr = flash_addr;
    regs.flash_data = flash_data;
    regs.sspbdat    = sspbdat;
  end

  assign int_n = ~(int_p & contr[`CONTR_INTEN_BIT]);  // Active low to the CPU

  a_fe_needs_dma: assert property (@(posedge sclk) disable iff (!rst_n)
    $rose(fe) |-> $past(dma_active))
    else $error("flush done set while DMA was idle");

endmodule

//--- read_mux.sv
// Result stage that registers read data and drives the CPU bus acknowledge
`timescale 1ns/1ns
`include "sdmac_settings.svh"

module read_mux import sdmac_pkg::*; (
  input  logic                     sclk,
  input  logic                     rst_n,
  reg_strobe_if.result_mp          strobe,
  input  sdmac_regs_t              regs,
  input  logic                     as_n,
  output logic [`SDMAC_DATA_W-1:0] rdata,
  output logic                     dtack_n
);

  logic [`SDMAC_DATA_W-1:0] rd_sel;

  // Snapshot is still the pre-write value at the valid edge
  always_comb begin
    rd_sel = '0;
    if (!strobe.write) begin
      case (strobe.sel)
        SEL_WTC:        rd_sel = regs.wtc;
        SEL_CONTR:      rd_sel = regs.contr;
        SEL_ACR:        rd_sel = regs.acr;
        SEL_ISTR:       rd_sel = regs.istr;
        SEL_VERSION:    rd_sel = `SDMAC_VERSION;
        SEL_FLASH_ADDR: rd_sel = regs.flash_addr;
        SEL_FLASH_DATA: rd_sel = regs.flash_data;
        SEL_DEV:        rd_sel = `SDMAC_DEV_ID;
        SEL_SSPBDAT:    rd_sel = regs.sspbdat;
        // SCSI chip, DSP, action strobes and holes read as zero
        default:        rd_sel = '0;
      endcase
    end
  end

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      rdata   <= '0;
      dtack_n <= 1'b1;
    end else if (strobe.valid) begin
      rdata   <= rd_sel;
      dtack_n <= 1'b0;
    end else if (as_n) begin
      dtack_n <= 1'b1;  // CPU has released the strobe
    end
  end

  a_dtack_in_cycle: assert property (@(posedge sclk) disable iff (!rst_n)
    !dtack_n |-> !$past(as_n))
    else $error("dtack_n low outside a bus cycle");

endmodule

//--- sdmac_top.sv
// SCSI DMA controller register side joining CPU bus decode, register block and read return
`timescale 1ns/1ns
`include "sdmac_settings.svh"

module sdmac_top import sdmac_pkg::*; (
  input  logic                     sclk,
  input  logic                     rst_n,

  // CPU bus
  input  logic [`SDMAC_ADDR_W-1:0] addr,
  input  logic                     dmac_n,    // Chip select
  input  logic                     as_n,      // Address strobe
  input  logic                     rw,        // 1 = read
  input  logic [`SDMAC_DATA_W-1:0] wdata,
  output logic [`SDMAC_DATA_W-1:0] rdata,
  output logic                     dtack_n,

  // SCSI side
  input  logic                     scsi_irq,
  input  logic                     dma_word,  // One pulse per transferred word
  output logic                     int_n,
  output logic                     dma_active,
  output logic                     wd_req
);

  sdmac_regs_t regs;

  reg_strobe_if strobe_if ();

  addr_decoder u_decoder (
    .sclk   (sclk),
    .rst_n  (rst_n),
    .addr   (addr),
    .dmac_n (dmac_n),
    .as_n   (as_n),
    .rw     (rw),
    .wdata  (wdata),
    .strobe (strobe_if.decoder_mp),
    .wd_req (wd_req)
  );

  // Execute stage
  dmac_regs u_regs (
    .sclk       (sclk),
    .rst_n      (rst_n),
    .strobe     (strobe_if.exec_mp),
    .scsi_irq   (scsi_irq),
    .dma_word   (dma_word),
    .regs       (regs),
    .int_n      (int_n),
    .dma_active (dma_active)
  );

  read_mux u_result (
    .sclk    (sclk),
    .rst_n   (rst_n),
    .strobe  (strobe_if.result_mp),
    .regs    (regs),
    .as_n    (as_n),
    .rdata   (rdata),
    .dtack_n (dtack_n)
  );

endmodule

//--- sdmac_tb.sv
// SDMAC testbench driving random CPU bus cycles and checking them against a register model
`timescale 1ns/1ns
`include "sdmac_settings.svh"

module sdmac_tb;

  localparam int NUM_ACCESSES = 400;
  localparam int MAX_CYCLES   = NUM_ACCESSES * 8 + 600;

  logic        sclk;
  logic        rst_n;
  logic [7:0]  addr;
  logic        dmac_n;
  logic        as_n;
  logic        rw;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        dtack_n;
  logic        scsi_irq;
  logic        dma_word;
  logic        int_n;
  logic        dma_active;
  logic        wd_req;

  logic [15:0] lfsr = 16'd95;
  int          cycle_cnt = 0;

  // Bus inputs for the next rising edge
  logic [7:0]  nxt_addr;
  logic        nxt_dmac_n;
  logic        nxt_as_n;
  logic        nxt_rw;
  logic [31:0] nxt_wdata;
  logic        drv_word;  // dma_word as seen at the coming edge
  logic        drv_irq;

  // Register model
  logic [31:0] m_contr;
  logic [31:0] m_acr;
  logic [31:0] m_wtc;
  logic [31:0] m_fa;
  logic [31:0] m_fd;
  logic [31:0] m_sp;
  logic        m_act;
  logic        m_fe;
  logic        m_intp;
  logic        m_irq_q;
  logic        pend_valid;  // Access executes at the coming edge
  logic [7:0]  pend_addr;
  logic        pend_write;
  logic [31:0] pend_wdata;

  sdmac_top dut (
    .sclk       (sclk),
    .rst_n      (rst_n),
    .addr       (addr),
    .dmac_n     (dmac_n),
    .as_n       (as_n),
    .rw         (rw),
    .wdata      (wdata),
    .rdata      (rdata),
    .dtack_n    (dtack_n),
    .scsi_irq   (scsi_irq),
    .dma_word   (dma_word),
    .int_n      (int_n),
    .dma_active (dma_active),
    .wd_req     (wd_req)
  );

  initial begin
    sclk = 1'b0;
    forever #2 sclk = ~sclk;
  end

  always @(posedge sclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the bus sequence never finished", cycle_cnt);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] model_istr();
    logic [31:0] r;
    r                    = '0;
    r[`ISTR_DMA_ACT_BIT] = m_act;
    r[`ISTR_FE_BIT]      = m_fe;
    r[`ISTR_INT_P_BIT]   = m_intp;
    return r;
  endfunction

  function automatic logic [31:0] exp_read(input logic [7:0] a);
    case (a)
      8'h04:   return m_wtc;
      8'h08:   return m_contr;
      8'h0C:   return m_acr;
      8'h1C:   return model_istr();
      8'h20:   return `SDMAC_VERSION;
      8'h24:   return m_fa;
      8'h28:   return m_fd;
      8'h2C:   return `SDMAC_DEV_ID;
      8'h58:   return m_sp;
      default: return '0;  // SCSI chip, DSP, actions and holes
    endcase
  endfunction

  // One clock that updates the model for this edge, drives new inputs and checks at the falling edge
  task automatic step();
    logic st;
    logic sp;
    logic fl;
    logic clr;
    logic old_act;
    logic rise;
    @(posedge sclk);
    st      = pend_valid && (pend_addr == 8'h10);
    sp      = pend_valid && (pend_addr == 8'h3C);
    fl      = pend_valid && (pend_addr == 8'h14);
    clr     = pend_valid && (pend_addr == 8'h18);
    old_act = m_act;
    rise    = drv_irq & ~m_irq_q;
    if (st) m_wtc = '0;
    else if (old_act && drv_word) m_wtc = m_wtc + 32'd1;
    if (st) m_act = 1'b1;
    else if (sp) m_act = 1'b0;
    if (st) m_fe = 1'b0;
    else if (fl && old_act) m_fe = 1'b1;
    if (rise) m_intp = 1'b1;
    else if (clr) m_intp = 1'b0;
    m_irq_q = drv_irq;
    if (pend_valid && pend_write) begin
      case (pend_addr)
        8'h08: m_contr = pend_wdata;
        8'h0C: m_acr = pend_wdata;
        8'h24: m_fa = pend_wdata;
        8'h28: m_fd = pend_wdata;
        8'h58: m_sp = pend_wdata;
        default: ;
      endcase
    end
    pend_valid = 1'b0;
    drv_word   = 1'(rand_bits(1));
    if (rand_bits(3) == 0) drv_irq = ~drv_irq;  // Rare irq toggles
    dma_word <= drv_word;
    scsi_irq <= drv_irq;
    addr     <= nxt_addr;
    dmac_n   <= nxt_dmac_n;
    as_n     <= nxt_as_n;
    rw       <= nxt_rw;
    wdata    <= nxt_wdata;
    @(negedge sclk);
    check("dma_active", 32'(m_act), 32'(dma_active));
    check("int_n", 32'(!(m_intp && m_contr[`CONTR_INTEN_BIT])), 32'(int_n));
  endtask

  task automatic bus_cycle(input logic [7:0] a, input logic rd, input logic [31:0] wd);
    int          count;
    logic [31:0] exp_rdata;
    nxt_addr   = a;
    nxt_rw     = rd;
    nxt_wdata  = wd;
    nxt_dmac_n = 1'b0;
    nxt_as_n   = 1'b0;
    step();
    count     = 0;
    exp_rdata = '0;
    do begin
      step();
      count++;
      if (count == 1) begin
        // Request seen at edge E executes at E+1 on pre-write values
        pend_valid = 1'b1;
        pend_addr  = a;
        pend_write = ~rd;
        pend_wdata = wd;
        exp_rdata  = rd ? exp_read(a) : '0;
      end
    end while (dtack_n && count < 8);
    check("dtack_n latency", 32'd2, 32'(count));
    check("rdata", exp_rdata, rdata);
    check("wd_req", 32'(a[7:4] == 4'h4), 32'(wd_req));
    nxt_as_n   = 1'b1;
    nxt_dmac_n = 1'b1;
    do begin
      step();
    end while (!dtack_n);
    check("wd_req", 32'd0, 32'(wd_req));
  endtask

  // Strobe with chip select high must be ignored
  task automatic ignored_cycle(input logic [7:0] a, input logic rd, input logic [31:0] wd);
    nxt_addr   = a;
    nxt_rw     = rd;
    nxt_wdata  = wd;
    nxt_dmac_n = 1'b1;
    nxt_as_n   = 1'b0;
    step();
    repeat (8) begin
      step();
      check("dtack_n", 32'd1, 32'(dtack_n));
      check("wd_req", 32'd0, 32'(wd_req));
    end
    nxt_as_n = 1'b1;
    step();
  endtask

  initial begin
    logic [3:0]  sel;
    logic [7:0]  a;
    logic        rd;
    logic [31:0] wd;
    rst_n      = 1'b0;
    addr       = '0;
    dmac_n     = 1'b1;
    as_n       = 1'b1;
    rw         = 1'b1;
    wdata      = '0;
    scsi_irq   = 1'b0;
    dma_word   = 1'b0;
    nxt_addr   = '0;
    nxt_dmac_n = 1'b1;
    nxt_as_n   = 1'b1;
    nxt_rw     = 1'b1;
    nxt_wdata  = '0;
    drv_word   = 1'b0;
    drv_irq    = 1'b0;
    m_contr    = '0;
    m_acr      = '0;
    m_wtc      = '0;
    m_fa       = '0;
    m_fd       = '0;
    m_sp       = '0;
    m_act      = 1'b0;
    m_fe       = 1'b0;
    m_intp     = 1'b0;
    m_irq_q    = 1'b0;
    pend_valid = 1'b0;
    pend_addr  = '0;
    pend_write = 1'b0;
    pend_wdata = '0;
    repeat (2) @(posedge sclk);
    rst_n <= 1'b1;
    bus_cycle(8'h20, 1'b1, '0);
    bus_cycle(8'h2C, 1'b1, '0);
    bus_cycle(8'h20, 1'b0, rand_bits(32));  // Constant must survive a write
    bus_cycle(8'h20, 1'b1, '0);
    bus_cycle(8'h08, 1'b0, 32'h0000_0004);  // INTEN on
    bus_cycle(8'h10, 1'b1, '0);
    repeat (8) step();
    bus_cycle(8'h14, 1'b1, '0);
    bus_cycle(8'h1C, 1'b1, '0);
    bus_cycle(8'h04, 1'b1, '0);
    for (int i = 0; i < NUM_ACCESSES; i++) begin
      sel = 4'(rand_bits(4));
      case (sel)
        4'd0:    a = 8'h04;
        4'd1:    a = 8'h08;
        4'd2:    a = 8'h0C;
        4'd3:    a = 8'h10;
        4'd4:    a = 8'h14;
        4'd5:    a = 8'h18;
        4'd6:    a = 8'h1C;
        4'd7:    a = 8'h20;
        4'd8:    a = 8'h24;
        4'd9:    a = 8'h28;
        4'd10:   a = 8'h2C;
        4'd11:   a = 8'h3C;
        4'd12:   a = {4'h4, 4'(rand_bits(4))};
        4'd13:   a = 8'h58;
        4'd14:   a = 8'h5C;
        default: a = 8'(rand_bits(8));  // Mostly holes
      endcase
      rd = 1'(rand_bits(1));
      wd = rand_bits(32);
      if (rand_bits(4) == 0) begin
        ignored_cycle(a, rd, wd);
      end else begin
        bus_cycle(a, rd, wd);
      end
      repeat (rand_bits(2)) step();
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
sdmac_pkg.sv
reg_strobe_if.sv
addr_decoder.sv
dmac_regs.sv
read_mux.sv
sdmac_top.sv
sdmac_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module sdmac_tb \
  -o sdmac_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sdmac_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
